//--- Makefile
# Verilator flow for the kicker I/O and sound section
# any variable can be set on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TB_TOP    ?= kicker_tb
RTL_TOP   ?= kicker_sound_io
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/kicker_tb.sv
//############################################################
// testbench for the I/O and sound section, replays the
// operations of the test data file and checks the outputs
//############################################################
`timescale 1ns/1ps
`default_nettype none

module kicker_tb;
    import kicker_map_pkg::*;

    logic               clk;
    logic               rst;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    io_addr_t           wb_adr;
    io_data_t           wb_dat_w;
    io_data_t           wb_dat_r;
    logic               wb_ack;
    logic               lvbl;
    logic               v16;
    logic [1:0]         start_button;
    logic [1:0]         coin_input;
    logic               service;
    logic [5:0]         joystick1;
    logic [5:0]         joystick2;
    io_data_t           dipsw_a;
    io_data_t           dipsw_b;
    logic [3:0]         dipsw_c;
    logic               psg_cen = 1'b0;
    logic [1:0]         cen_cnt = 2'd0;
    logic               flip;
    logic [2:0]         pal_sel;
    logic               irq_n;
    logic               firq_n;
    logic signed [15:0] snd;
    logic               sample;
    logic               peak;

    // second DUT, own cyc and outputs, everything else shared
    logic               sat_cyc;
    io_data_t           sat_dat_r;
    logic               sat_ack;
    logic signed [15:0] sat_snd;
    logic               sat_peak;

    int          seed = 32'hef884910;
    int          fd;
    int          fields;
    int          gap;
    string       line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    io_data_t    rdata;
    int          latency;

    kicker_sound_io uut (.*);

    // two chips top out below the clip level even at the largest 4.4 gain,
    // four chips at full gain go past it
    kicker_sound_io #(.N_PSG(4), .MIX_GAIN(8'hff)) sat_dut (
        .*,
        .wb_cyc   (sat_cyc),
        .wb_dat_r (sat_dat_r),
        .wb_ack   (sat_ack),
        .flip     (),
        .pal_sel  (),
        .irq_n    (),
        .firq_n   (),
        .snd      (sat_snd),
        .sample   (),
        .peak     (sat_peak)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        cen_cnt <= cen_cnt + 2'd1;
        psg_cen <= cen_cnt == 2'd3;   // one clk in four
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // one classic cycle, starts and ends on a falling edge
    task automatic bus_cycle(input logic to_sat, input logic we, input io_addr_t adr,
                             input io_data_t wdata, output io_data_t rd,
                             output int cycles);
        cycles = 0;
        if (to_sat) begin
            sat_cyc = 1'b1;
        end else begin
            wb_cyc = 1'b1;
        end
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 64) begin
                fail_run("timeout waiting for Wishbone ack");
            end
        end while (!(to_sat ? sat_ack : wb_ack));
        rd      = to_sat ? sat_dat_r : wb_dat_r;
        wb_cyc  = 1'b0;
        sat_cyc = 1'b0;
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
    endtask

    // data latch write, then the trigger that hands it to the chip
    task automatic sound_write(input logic to_sat, input logic [2:0] chip,
                               input io_data_t value, input logic expect_wait);
        io_data_t unused;
        int       cycles;
        bus_cycle(to_sat, 1'b1, {region_snd_data, 8'h00, chip}, value, unused, cycles);
        bus_cycle(to_sat, 1'b1, {region_ctrl, sub_trigger, 5'h00, chip}, 8'h00,
                  unused, cycles);
        if (expect_wait) begin
            check_value(32'(cycles > 2), 32'd1, "trigger ack held off while chip is busy");
        end
    endtask

    task automatic wait_samples(input logic [31:0] ticks);
        int cycles;
        repeat (ticks) begin
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
                if (cycles > 16) begin
                    fail_run("timeout waiting for a mixer sample pulse");
                end
            end while (!sample);
        end
    endtask

    task automatic drive_video(input logic is_v16, input logic level,
                               input logic exp_irq_n, input logic exp_firq_n);
        int cycles;
        if (is_v16) begin
            v16 = level;
        end else begin
            lvbl = level;
        end
        cycles = 0;
        while (irq_n !== exp_irq_n || firq_n !== exp_firq_n) begin
            @(negedge clk);
            cycles++;
            if (cycles > 8) begin
                fail_run("timeout waiting for the interrupt outputs");
            end
        end
        repeat (3) @(negedge clk);   // no late change allowed
        check_value(32'(irq_n), 32'(exp_irq_n), "irq_n");
        check_value(32'(firq_n), 32'(exp_firq_n), "firq_n");
    endtask

    task automatic run_op();
        case (op)
            "W": bus_cycle(1'b0, 1'b1, a[13:0], b[7:0], rdata, latency);
            "R": begin
                bus_cycle(1'b0, 1'b0, a[13:0], 8'h00, rdata, latency);
                check_value(32'(rdata), b, $sformatf("read data at %h", a[13:0]));
            end
            "I": begin
                {start_button, service, coin_input} = a[4:0];
                {joystick2, joystick1}              = b[11:0];
                {dipsw_c, dipsw_b, dipsw_a}         = c[19:0];
            end
            "C": begin
                check_value(32'(flip), a, "flip");
                check_value(32'(pal_sel), b, "pal_sel");
            end
            "L": drive_video(1'b0, a[0], b[0], c[0]);
            "F": drive_video(1'b1, a[0], b[0], c[0]);
            "T": sound_write(1'b0, a[2:0], b[7:0], c[0]);
            "X": begin
                for (int i = 0; i < int'(b); i++) begin
                    sound_write(1'b1, 3'(i), a[7:0], 1'b0);
                end
            end
            "S": begin
                wait_samples(a);
                check_value(32'(snd), b, "snd");
                check_value(32'(peak), c, "peak");
            end
            "P": begin
                wait_samples(a);
                check_value(32'(sat_snd), b, "snd of the four chip DUT");
                check_value(32'(sat_peak), c, "peak of the four chip DUT");
            end
            default: fail_run($sformatf("unknown operation %c in the test data", op));
        endcase
    endtask

    initial begin
        rst          = 1'b1;
        wb_cyc       = 1'b0;
        sat_cyc      = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        lvbl         = 1'b1;   // blank inactive
        v16          = 1'b0;
        start_button = '0;
        coin_input   = '0;
        service      = 1'b0;
        joystick1    = '0;
        joystick2    = '0;
        dipsw_a      = '0;
        dipsw_b      = '0;
        dipsw_c      = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        fd = $fopen("bench/kicker_testdata.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open bench/kicker_testdata.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%c %h %h %h", op, a, b, c);
            if (fields == 4 && op != "#") begin
                run_op();
                gap = $random(seed) & 3;
                repeat (gap) @(negedge clk);
            end
        end
        $fclose(fd);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/kicker_testdata.txt
# op a b c, all fields hex
# W adr data 0 | R adr expected 0 | I {start,service,coin} {joy2,joy1} {dipc,dipb,dipa}
# C flip pal_sel 0 | L lvbl irq_n firq_n | F v16 irq_n firq_n | T chip byte held_off
# X byte chips 0 (four chip DUT) | S ticks snd peak | P ticks snd peak (four chip DUT)
I 15 6a5 35ac3
R 0700 f5 0
R 0701 ea 0
R 0702 d5 0
R 0703 c3 0
R 0500 5a 0
R 0600 f3 0
R 0000 ff 0
R 0100 ff 0
R 1000 ff 0
R 2800 ff 0
I 0a fd3 e007f
R 0700 ea 0
R 0701 d3 0
R 0702 ff 0
R 0703 7f 0
R 0500 00 0
R 0600 fe 0
C 0 0 0
W 0000 01 0
W 1800 05 0
C 1 5 0
W 1000 00 0
W 3800 07 0
W 0100 06 0
C 1 5 0
L 0 1 1
L 1 1 1
F 1 1 1
F 0 1 1
W 0000 06 0
C 0 5 0
L 0 0 1
L 1 0 1
F 1 0 0
W 0000 02 0
L 1 1 0
W 0000 00 0
F 1 1 1
S 2 0000 0
T 0 81 0
T 0 90 1
S 2 00ff 0
T 0 b3 0
T 1 d6 0
S 2 01bf 0
T 5 9f 0
S 2 01bf 0
P 2 0000 0
X 90 4 0
X b0 4 0
X d0 4 0
P 2 7fff 1
S 2 01bf 0

//--- sim.f
verilog/kicker_map_pkg.sv
verilog/psg_pkg.sv
verilog/psg_bus_if.sv
verilog/kicker_io_decode.sv
verilog/kicker_irq.sv
verilog/psg_core.sv
verilog/psg_mixer.sv
verilog/kicker_sound_io.sv
bench/kicker_tb.sv

//--- verilog/kicker_io_decode.sv
//############################################################
// Wishbone slave for the I/O page: decode, read mux,
// configuration latches and sound chip write control
//############################################################
`timescale 1ns/1ps
`default_nettype none

module kicker_io_decode #(
    parameter int N_PSG = 2
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  kicker_map_pkg::io_addr_t  wb_adr,
    input  kicker_map_pkg::io_data_t  wb_dat_w,
    output kicker_map_pkg::io_data_t  wb_dat_r,
    output logic                      wb_ack,
    input  logic [1:0]                start_button,
    input  logic [1:0]                coin_input,
    input  logic                      service,
    input  logic [5:0]                joystick1,
    input  logic [5:0]                joystick2,
    input  kicker_map_pkg::io_data_t  dipsw_a,
    input  kicker_map_pkg::io_data_t  dipsw_b,
    input  logic [3:0]                dipsw_c,
    output logic                      flip,
    output logic                      irq_en,
    output logic                      firq_en,
    output logic [2:0]                pal_sel,
    psg_bus_if.ctrl                   psg
);
    import kicker_map_pkg::*;

    typedef enum logic {st_idle, st_wait_ready} state_t;

    state_t           state;
    io_region_t       region;
    io_region_t       sub_page;
    logic [2:0]       chip_idx;
    logic             start;
    logic             is_ctrl;
    logic             is_trig;
    logic             is_data;
    logic             is_pal;
    logic             chip_ok;
    logic             chip_ready;
    logic [N_PSG-1:0] sel;
    io_data_t         chip_byte;
    io_data_t         rd_byte;
    io_data_t         data_latch [N_PSG];

    assign region   = wb_adr[13:11];
    assign sub_page = wb_adr[10:8];
    assign chip_idx = wb_adr[2:0];

    assign start   = wb_cyc && wb_stb && !wb_ack && state == st_idle;
    assign is_ctrl = region == region_ctrl && sub_page == sub_ctrl;
    assign is_trig = region == region_ctrl && sub_page == sub_trigger;
    assign is_data = region == region_snd_data;
    assign is_pal  = region == region_pal;
    assign chip_ok = int'(chip_idx) < N_PSG;

    // one-hot chip select and the byte waiting in its latch
    always_comb begin
        sel       = '0;
        chip_byte = '0;
        for (int i = 0; i < N_PSG; i++) begin
            if (chip_idx == 3'(i)) begin
                sel[i]    = 1'b1;
                chip_byte = data_latch[i];
            end
        end
    end

    assign chip_ready = |(psg.ready & sel);
    assign psg.sel    = sel;
    assign psg.data   = chip_byte;
    assign psg.wr     = state == st_wait_ready && chip_ready;

    always_comb begin
        rd_byte = unmapped_byte;
        if (region == region_ctrl) begin
            case (sub_page)
                sub_dip_b: rd_byte = dipsw_b;
                sub_dip_c: rd_byte = {4'hf, dipsw_c};
                sub_cabinet: begin
                    case (wb_adr[1:0])
                        cab_system: rd_byte = system_byte(start_button, service, coin_input);
                        cab_joy1:   rd_byte = joy_byte(joystick1);
                        cab_joy2:   rd_byte = joy_byte(joystick2);
                        cab_dip_a:  rd_byte = dipsw_a;
                    endcase
                end
                default: rd_byte = unmapped_byte;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= st_idle;
            wb_ack  <= 1'b0;
            flip    <= 1'b0;
            irq_en  <= 1'b0;
            firq_en <= 1'b0;
            pal_sel <= '0;
        end else begin
            wb_ack <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        if (is_trig && wb_we && chip_ok) begin
                            state <= st_wait_ready;   // ack once the chip takes it
                        end else begin
                            wb_ack <= 1'b1;
                        end
                        if (wb_we && is_ctrl) begin
                            flip    <= wb_dat_w[ctrl_flip];
                            firq_en <= wb_dat_w[ctrl_firq_en];
                            irq_en  <= wb_dat_w[ctrl_irq_en];
                        end
                        if (wb_we && is_pal) begin
                            pal_sel <= wb_dat_w[2:0];
                        end
                    end
                end
                st_wait_ready: begin
                    if (chip_ready) begin
                        state  <= st_idle;
                        wb_ack <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            wb_dat_r <= rd_byte;
        end
        for (int i = 0; i < N_PSG; i++) begin
            if (start && wb_we && is_data && chip_idx == 3'(i)) begin
                data_latch[i] <= wb_dat_w;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/kicker_irq.sv
//############################################################
// vblank and V16 interrupt requests, edge set and cleared
// while the enable bit is low
//############################################################
`timescale 1ns/1ps
`default_nettype none

module kicker_irq (
    input  logic clk,
    input  logic rst,
    input  logic lvbl,
    input  logic v16,
    input  logic irq_en,
    input  logic firq_en,
    output logic irq_n,
    output logic firq_n
);
    logic lvbl_s;
    logic lvbl_l;
    logic v16_s;
    logic v16_l;
    logic irq_req;
    logic firq_req;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_s   <= 1'b1;   // idle levels, no edge out of reset
            lvbl_l   <= 1'b1;
            v16_s    <= 1'b0;
            v16_l    <= 1'b0;
            irq_req  <= 1'b0;
            firq_req <= 1'b0;
        end else begin
            lvbl_s <= lvbl;
            lvbl_l <= lvbl_s;
            v16_s  <= v16;
            v16_l  <= v16_s;
            // writing a zero enable acts as the acknowledge
            if (!irq_en) begin
                irq_req <= 1'b0;
            end else if (lvbl_l && !lvbl_s) begin
                irq_req <= 1'b1;
            end
            if (!firq_en) begin
                firq_req <= 1'b0;
            end else if (!v16_l && v16_s) begin
                firq_req <= 1'b1;
            end
        end
    end

    assign irq_n  = ~irq_req;
    assign firq_n = ~firq_req;

endmodule

`default_nettype wire

//--- verilog/kicker_map_pkg.sv
//############################################################
// kicker I/O map: bus types, region decode codes and the
// bit ordering of the cabinet and DIP read bytes
//############################################################
`default_nettype none

package kicker_map_pkg;

    typedef logic [13:0] io_addr_t;   // byte address inside the I/O page
    typedef logic [7:0]  io_data_t;
    typedef logic [2:0]  io_region_t;

    // region field is adr[13:11], sub-page is adr[10:8]
    localparam io_region_t region_ctrl     = 3'd0;
    localparam io_region_t region_snd_data = 3'd1;
    localparam io_region_t region_pal      = 3'd3;

    localparam io_region_t sub_ctrl    = 3'd0;
    localparam io_region_t sub_trigger = 3'd3;
    localparam io_region_t sub_dip_b   = 3'd5;
    localparam io_region_t sub_dip_c   = 3'd6;
    localparam io_region_t sub_cabinet = 3'd7;

    // cabinet selector, adr[1:0]
    localparam logic [1:0] cab_system = 2'd0;
    localparam logic [1:0] cab_joy1   = 2'd1;
    localparam logic [1:0] cab_joy2   = 2'd2;
    localparam logic [1:0] cab_dip_a  = 2'd3;

    localparam int ctrl_flip    = 0;
    localparam int ctrl_firq_en = 1;
    localparam int ctrl_irq_en  = 2;

    localparam io_data_t unmapped_byte = 8'hff;

    function automatic io_data_t system_byte(logic [1:0] start, logic service, logic [1:0] coin);
        return {3'b111, start, service, coin};
    endfunction

    // joystick directions are swapped in pairs in the read byte
    function automatic io_data_t joy_byte(logic [5:0] joy);
        return {2'b11, joy[5:4], joy[2], joy[3], joy[0], joy[1]};
    endfunction

endpackage

`default_nettype wire

//--- verilog/kicker_sound_io.sv
//############################################################
// I/O and sound section top: decoder, interrupts,
// sound chip array and mixer
//############################################################
`timescale 1ns/1ps
`default_nettype none

module kicker_sound_io #(
    parameter int         N_PSG    = 2,
    parameter logic [7:0] MIX_GAIN = 8'h10
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  kicker_map_pkg::io_addr_t wb_adr,
    input  kicker_map_pkg::io_data_t wb_dat_w,
    output kicker_map_pkg::io_data_t wb_dat_r,
    output logic                     wb_ack,
    input  logic                     lvbl,
    input  logic                     v16,
    input  logic [1:0]               start_button,
    input  logic [1:0]               coin_input,
    input  logic                     service,
    input  logic [5:0]               joystick1,
    input  logic [5:0]               joystick2,
    input  kicker_map_pkg::io_data_t dipsw_a,
    input  kicker_map_pkg::io_data_t dipsw_b,
    input  logic [3:0]               dipsw_c,
    input  logic                     psg_cen,
    output logic                     flip,
    output logic [2:0]               pal_sel,
    output logic                     irq_n,
    output logic                     firq_n,
    output logic signed [15:0]       snd,
    output logic                     sample,
    output logic                     peak
);
    import psg_pkg::*;

    logic                        irq_en;
    logic                        firq_en;
    psg_sample_t [N_PSG-1:0]     chip_snd;

    psg_bus_if #(.N_PSG(N_PSG)) psg ();

    kicker_io_decode #(.N_PSG(N_PSG)) u_decode (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .flip         (flip),
        .irq_en       (irq_en),
        .firq_en      (firq_en),
        .pal_sel      (pal_sel),
        .psg          (psg.ctrl)
    );

    kicker_irq u_irq (
        .clk     (clk),
        .rst     (rst),
        .lvbl    (lvbl),
        .v16     (v16),
        .irq_en  (irq_en),
        .firq_en (firq_en),
        .irq_n   (irq_n),
        .firq_n  (firq_n)
    );

    for (genvar i = 0; i < N_PSG; i++) begin : g_psg
        psg_core #(.CHIP_ID(i)) u_psg (
            .clk     (clk),
            .rst     (rst),
            .psg_cen (psg_cen),
            .bus     (psg.chip),
            .sample  (chip_snd[i])
        );
    end

    psg_mixer #(.N_PSG(N_PSG), .MIX_GAIN(MIX_GAIN)) u_mixer (
        .clk     (clk),
        .rst     (rst),
        .psg_cen (psg_cen),
        .chan    (chip_snd),
        .snd     (snd),
        .sample  (sample),
        .peak    (peak)
    );

endmodule

`default_nettype wire

//--- verilog/psg_bus_if.sv
//############################################################
// write path from the I/O decoder to the sound chip array
//############################################################
`timescale 1ns/1ps
`default_nettype none

interface psg_bus_if #(
    parameter int N_PSG = 2
);
    import psg_pkg::*;

    logic             wr;      // one cycle strobe
    logic [N_PSG-1:0] sel;
    psg_byte_t        data;
    wire  [N_PSG-1:0] ready;   // each chip drives its own bit

    modport ctrl (output wr, sel, data, input ready);
    modport chip (input wr, sel, data, output ready);

endinterface

`default_nettype wire

//--- verilog/psg_core.sv
//############################################################
// SN76489 style sound generator: three tones, one noise
// channel, attenuation and a busy time after each write
//############################################################
`timescale 1ns/1ps
`default_nettype none

module psg_core #(
    parameter int CHIP_ID = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 psg_cen,
    psg_bus_if.chip              bus,
    output psg_pkg::psg_sample_t sample
);
    import psg_pkg::*;

    psg_period_t period [3];
    psg_period_t tone_cnt [3];
    logic [2:0]  tone_out;
    logic [2:0]  tone_wrap;
    psg_atten_t  atten [4];
    logic [2:0]  noise_ctrl;   // bit 2 white noise, 1..0 rate
    logic [1:0]  last_chan;
    logic        last_vol;
    logic [14:0] lfsr;
    logic [5:0]  noise_div;
    logic        noise_tick;
    logic        noise_fb;
    logic        write;
    psg_latch_t  cmd;
    psg_busy_t   busy_cnt;
    logic [3:0]  chan_on;

    assign write = bus.wr & bus.sel[CHIP_ID];
    assign cmd   = bus.data;
    assign bus.ready[CHIP_ID] = busy_cnt == '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                period[i] <= '0;
            end
            for (int i = 0; i < 4; i++) begin
                atten[i] <= 4'hf;   // all channels silent
            end
            noise_ctrl <= '0;
            last_chan  <= '0;
            last_vol   <= 1'b0;
        end else if (write) begin
            if (cmd.latch) begin
                last_chan <= cmd.chan;
                last_vol  <= cmd.vol;
                if (cmd.vol) begin
                    atten[cmd.chan] <= cmd.data;
                end else if (cmd.chan == 2'd3) begin
                    noise_ctrl <= cmd.data[2:0];
                end else begin
                    period[cmd.chan][3:0] <= cmd.data;
                end
            end else if (!last_vol && last_chan != 2'd3) begin
                period[last_chan][9:4] <= bus.data[5:0];   // upper period bits
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            tone_wrap[i] = period[i] > 10'd1 && tone_cnt[i] >= period[i] - 10'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                tone_cnt[i] <= '0;
            end
            tone_out <= '1;
        end else if (psg_cen) begin
            for (int i = 0; i < 3; i++) begin
                if (period[i] < 10'd2) begin
                    tone_cnt[i] <= '0;
                    tone_out[i] <= 1'b1;   // period 0 or 1 holds high
                end else if (tone_wrap[i]) begin
                    tone_cnt[i] <= '0;
                    tone_out[i] <= ~tone_out[i];
                end else begin
                    tone_cnt[i] <= tone_cnt[i] + 10'd1;
                end
            end
        end
    end

    always_comb begin
        case (noise_ctrl[1:0])
            2'd0:    noise_tick = noise_div[3:0] == '1;
            2'd1:    noise_tick = noise_div[4:0] == '1;
            2'd2:    noise_tick = noise_div == '1;
            default: noise_tick = tone_wrap[2] & ~tone_out[2];   // follows tone 2
        endcase
    end

    assign noise_fb = noise_ctrl[2] ? lfsr[0] ^ lfsr[1] : lfsr[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr      <= 15'h4000;
            noise_div <= '0;
        end else begin
            if (psg_cen) begin
                noise_div <= noise_div + 6'd1;
            end
            if (write && cmd.latch && !cmd.vol && cmd.chan == 2'd3) begin
                lfsr <= 15'h4000;   // new noise mode restarts the shifter
            end else if (psg_cen && noise_tick) begin
                lfsr <= {noise_fb, lfsr[14:1]};
            end
        end
    end

    assign chan_on = {lfsr[0], tone_out};

    always_comb begin
        sample = '0;
        for (int i = 0; i < 4; i++) begin
            if (chan_on[i]) begin
                sample = sample + psg_sample_t'(psg_atten_table[atten[i]]);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_cnt <= '0;
        end else if (write) begin
            busy_cnt <= psg_busy_ticks;
        end else if (psg_cen && busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 3'd1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/psg_mixer.sv
//############################################################
// sound mixer: sums the chips, applies a 4.4 gain and
// saturates with a peak flag
//############################################################
`timescale 1ns/1ps
`default_nettype none

module psg_mixer #(
    parameter int         N_PSG    = 2,
    parameter logic [7:0] MIX_GAIN = 8'h10
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             psg_cen,
    input  psg_pkg::psg_sample_t [N_PSG-1:0] chan,
    output logic signed [15:0]               snd,
    output logic                             sample,
    output logic                             peak
);
    logic [12:0] sum;      // room for eight chips
    logic [20:0] scaled;
    logic        over;

    always_comb begin
        sum = '0;
        for (int i = 0; i < N_PSG; i++) begin
            sum = sum + 13'(chan[i]);
        end
    end

    assign scaled = 21'(sum) * 21'(MIX_GAIN);
    assign over   = |scaled[20:19];   // above 32767 after the shift

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd    <= '0;
            peak   <= 1'b0;
            sample <= 1'b0;
        end else begin
            sample <= psg_cen;
            if (psg_cen) begin
                snd  <= over ? 16'sh7fff : signed'({1'b0, scaled[18:4]});
                peak <= over;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/psg_pkg.sv
//############################################################
// sound generator types, command byte layout and the
// attenuation to amplitude table
//############################################################
`default_nettype none

package psg_pkg;

    typedef logic [9:0] psg_sample_t;   // sum of four channels
    typedef logic [7:0] psg_level_t;
    typedef logic [9:0] psg_period_t;
    typedef logic [3:0] psg_atten_t;
    typedef logic [7:0] psg_byte_t;
    typedef logic [2:0] psg_busy_t;

    // layout of a latch byte, a data byte only uses bits 5..0
    typedef struct packed {
        logic       latch;
        logic [1:0] chan;
        logic       vol;
        logic [3:0] data;
    } psg_latch_t;

    localparam psg_busy_t psg_busy_ticks = 3'd4;

    // roughly 2 dB per step, last one is off
    localparam psg_level_t psg_atten_table [16] = '{
        8'd255, 8'd203, 8'd161, 8'd128, 8'd102, 8'd81, 8'd64, 8'd51,
        8'd40,  8'd32,  8'd26,  8'd20,  8'd16,  8'd13, 8'd10, 8'd0
    };

endpackage

`default_nettype wire
